// File: hdl/gomoku_pkg.sv
// gomoku shared definitions: board geometry, key codes, release threshold and game types
`default_nettype none

package gomoku_pkg;

    // board is square, rows and columns both run 0..BOARD_N-1
    localparam int BOARD_N = 16;
    localparam int WIN_LEN = 5;      // stones in a line needed to win

    // idle raw samples in a row before a held key counts as released
    localparam int RELEASE_TH = 6;
    localparam int RELEASE_CNT_W = $clog2(RELEASE_TH + 1);

    typedef logic [3:0] coord_t;     // row or column index
    typedef logic [3:0] key_code_t;  // raw keypad code, most of the 16 values mean nothing

    // keypad layout: 2/4/6/8 form a cross around 5
    localparam key_code_t KEY_UP    = 4'd6;  // row - 1
    localparam key_code_t KEY_DOWN  = 4'd4;  // row + 1
    localparam key_code_t KEY_LEFT  = 4'd2;  // col - 1
    localparam key_code_t KEY_RIGHT = 4'd8;  // col + 1
    localparam key_code_t KEY_PLACE = 4'd5;  // confirm, same as the button

    // one encoding serves both as cell content and as the player on turn
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        PLAYER_1   = 2'b01,
        PLAYER_2   = 2'b10
    } player_t;

    // outcome of the most recent placement attempt
    typedef enum logic [1:0] {
        RESULT_NONE = 2'b00,
        RESULT_OK   = 2'b01,
        RESULT_FAIL = 2'b10
    } place_result_t;

    // controller states
    typedef enum logic [1:0] {
        ST_PLAY  = 2'b00,  // waiting for moves and placements
        ST_CHECK = 2'b01,  // stone written, waiting to judge the line
        ST_OVER  = 2'b10   // someone won, frozen until reset
    } ctrl_state_t;

    // whole board, indexed [row][col], 2 bits per cell
    typedef player_t [BOARD_N-1:0][BOARD_N-1:0] board_t;

endpackage

`default_nettype wire

// File: hdl/key_event_filter.sv
// key event filter: turns a held raw key level into a single one-cycle key event
`timescale 1ns/1ns
`default_nettype none

module key_event_filter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  raw_valid,   // level, stays high while the key is down
    input  gomoku_pkg::key_code_t raw_code,
    output logic                 key_valid,   // one pulse per press
    output gomoku_pkg::key_code_t key_code     // held until the next press
);

    import gomoku_pkg::*;

    logic                     held;      // a press is in progress
    logic [RELEASE_CNT_W-1:0] miss_cnt;  // idle samples seen since the last high one
    logic                     released;
    logic                     press;

    // the idle run has reached the threshold, so the key counts as let go
    assign released = held && (miss_cnt == RELEASE_CNT_W'(RELEASE_TH));

    // a high sample starts a new press when nothing is held or the hold just ran out
    assign press = raw_valid && (!held || released);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held      <= 1'b0;
            miss_cnt  <= '0;
            key_valid <= 1'b0;
            key_code  <= '0;
        end else begin
            key_valid <= 1'b0;                  // default, pulse lasts one cycle only
            if (press) begin
                held      <= 1'b1;
                miss_cnt  <= '0;
                key_valid <= 1'b1;
                key_code  <= raw_code;          // code is taken from the first sample
            end else if (released) begin
                held     <= 1'b0;               // re-armed for the next press
                miss_cnt <= '0;
            end else if (held) begin
                if (raw_valid) begin
                    miss_cnt <= '0;             // key bounced back, restart the idle run
                end else begin
                    miss_cnt <= miss_cnt + 1'b1;  // bounded by released above
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/game_ctrl.sv
// game controller: cursor movement, stone placement, turn swap and game over
`timescale 1ns/1ns
`default_nettype none

module game_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      key_valid,
    input  gomoku_pkg::key_code_t     key_code,
    input  wire                      btn,          // active low confirm button
    input  gomoku_pkg::player_t       cell_data,    // content of the cell under the cursor
    input  wire                      win,          // from the line checker, combinational
    output logic                     place_en,
    output gomoku_pkg::coord_t        cursor_row,
    output gomoku_pkg::coord_t        cursor_col,
    output gomoku_pkg::player_t       current_player,
    output gomoku_pkg::coord_t        last_row,
    output gomoku_pkg::coord_t        last_col,
    output gomoku_pkg::player_t       last_player,
    output gomoku_pkg::place_result_t place_result,
    output logic                     game_over,
    output gomoku_pkg::player_t       winner
);

    import gomoku_pkg::*;

    localparam coord_t EDGE_MAX = coord_t'(BOARD_N - 1);

    ctrl_state_t state;
    logic        btn_prev;    // last btn level, idles high
    logic        btn_fall;
    logic        confirm;

    assign btn_fall = btn_prev && !btn;   // a press is the 1 to 0 transition

    // keypad 5 and the button are both a placement request
    assign confirm = btn_fall || (key_valid && (key_code == KEY_PLACE));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= ST_PLAY;
            btn_prev       <= 1'b1;
            place_en       <= 1'b0;
            cursor_row     <= '0;
            cursor_col     <= '0;
            current_player <= PLAYER_1;
            last_row       <= '0;
            last_col       <= '0;
            last_player    <= CELL_EMPTY;     // keeps the checker quiet until the first stone
            place_result   <= RESULT_NONE;
            game_over      <= 1'b0;
            winner         <= CELL_EMPTY;
        end else begin
            btn_prev <= btn;
            place_en <= 1'b0;

            case (state)
                ST_PLAY: begin
                    if (confirm) begin
                        if (cell_data == CELL_EMPTY) begin
                            place_en     <= 1'b1;        // board writes on the next edge
                            place_result <= RESULT_OK;
                            last_row     <= cursor_row;
                            last_col     <= cursor_col;
                            last_player  <= current_player;
                            state        <= ST_CHECK;
                        end else begin
                            place_result <= RESULT_FAIL; // occupied, turn stays
                        end
                    end else if (key_valid) begin
                        // every move key clears the result, even when clamped at an edge
                        case (key_code)
                            KEY_UP: begin
                                if (cursor_row != '0) cursor_row <= cursor_row - 1'b1;
                                place_result <= RESULT_NONE;
                            end
                            KEY_DOWN: begin
                                if (cursor_row != EDGE_MAX) cursor_row <= cursor_row + 1'b1;
                                place_result <= RESULT_NONE;
                            end
                            KEY_LEFT: begin
                                if (cursor_col != '0) cursor_col <= cursor_col - 1'b1;
                                place_result <= RESULT_NONE;
                            end
                            KEY_RIGHT: begin
                                if (cursor_col != EDGE_MAX) cursor_col <= cursor_col + 1'b1;
                                place_result <= RESULT_NONE;
                            end
                            default: ;                   // codes without meaning are dropped
                        endcase
                    end
                end

                ST_CHECK: begin
                    // while place_en is still high the board has not taken the stone yet,
                    // so the win line is only valid one cycle later
                    if (!place_en) begin
                        if (win) begin
                            game_over <= 1'b1;
                            winner    <= last_player;
                            state     <= ST_OVER;
                        end else begin
                            current_player <= (current_player == PLAYER_1) ? PLAYER_2 : PLAYER_1;
                            state          <= ST_PLAY;
                        end
                    end
                end

                ST_OVER: ;   // frozen, only reset leaves this state

                default: state <= ST_PLAY;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/board_mem.sv
// board memory holding every cell, written on placement and read back at the cursor
`timescale 1ns/1ns
`default_nettype none

module board_mem (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 place_en,   // one-cycle write strobe from the controller
    input  gomoku_pkg::coord_t   row,
    input  gomoku_pkg::coord_t   col,
    input  gomoku_pkg::player_t  player,
    output gomoku_pkg::player_t  cell_data,  // cell under the cursor
    output gomoku_pkg::board_t   board       // full view for the line checker
);

    import gomoku_pkg::*;

    // each accepted placement drops one stone on a cell the controller found empty
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // a new game starts on an empty board
            for (int r = 0; r < BOARD_N; r++) begin
                for (int c = 0; c < BOARD_N; c++) begin
                    board[r][c] <= CELL_EMPTY;
                end
            end
        end else if (place_en) begin
            board[row][col] <= player;
        end
    end

    // read port follows the cursor without a clock
    assign cell_data = board[row][col];

endmodule

`default_nettype wire

// File: hdl/five_row_checker.sv
// five-in-a-row checker: counts same-player runs through the last stone in four directions
`timescale 1ns/1ns
`default_nettype none

module five_row_checker (
    input  gomoku_pkg::board_t   board,
    input  gomoku_pkg::coord_t   last_row,
    input  gomoku_pkg::coord_t   last_col,
    input  gomoku_pkg::player_t  last_player,
    output logic                win
);

    import gomoku_pkg::*;

    // stones of player p next to (r0,c0) along (dr,dc), not counting the centre,
    // looking at most WIN_LEN-1 cells out and stopping at an edge or a foreign cell
    function automatic int run_len(
        input board_t  b,
        input coord_t  r0,
        input coord_t  c0,
        input player_t p,
        input int      dr,
        input int      dc
    );
        int n;
        int r;
        int c;
        bit stop;
        n    = 0;
        stop = 1'b0;
        for (int k = 1; k < WIN_LEN; k++) begin
            r = int'(r0) + dr * k;
            c = int'(c0) + dc * k;
            if (!stop) begin
                if (r >= 0 && r < BOARD_N && c >= 0 && c < BOARD_N && b[r][c] == p) begin
                    n++;
                end else begin
                    stop = 1'b1;      // the run is broken, nothing further counts
                end
            end
        end
        return n;
    endfunction

    int line_h;     // along the row
    int line_v;     // along the column
    int line_d;     // down-right diagonal
    int line_a;     // down-left diagonal

    // each line is the centre stone plus both arms
    assign line_h = 1 + run_len(board, last_row, last_col, last_player, 0, 1)
                      + run_len(board, last_row, last_col, last_player, 0, -1);
    assign line_v = 1 + run_len(board, last_row, last_col, last_player, 1, 0)
                      + run_len(board, last_row, last_col, last_player, -1, 0);
    assign line_d = 1 + run_len(board, last_row, last_col, last_player, 1, 1)
                      + run_len(board, last_row, last_col, last_player, -1, -1);
    assign line_a = 1 + run_len(board, last_row, last_col, last_player, 1, -1)
                      + run_len(board, last_row, last_col, last_player, -1, 1);

    // no stone placed yet means there is nothing to judge
    assign win = (last_player != CELL_EMPTY) &&
                 (line_h >= WIN_LEN || line_v >= WIN_LEN ||
                  line_d >= WIN_LEN || line_a >= WIN_LEN);

endmodule

`default_nettype wire

// File: hdl/gomoku_core.sv
// gomoku core top: key filter, controller, board memory and line checker chained together
`timescale 1ns/1ns
`default_nettype none

module gomoku_core (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      raw_valid,      // scanned key level
    input  gomoku_pkg::key_code_t     raw_code,
    input  wire                      btn,            // active low confirm
    output gomoku_pkg::coord_t        cursor_row,
    output gomoku_pkg::coord_t        cursor_col,
    output gomoku_pkg::player_t       current_player,
    output gomoku_pkg::place_result_t place_result,
    output logic                     game_over,
    output gomoku_pkg::player_t       winner
);

    import gomoku_pkg::*;

    logic      key_valid;     // one pulse per press
    key_code_t key_code;
    logic      place_en;
    player_t   cell_data;     // board content under the cursor
    board_t    board;
    coord_t    last_row;      // last accepted stone, for the checker
    coord_t    last_col;
    player_t   last_player;
    logic      win;

    key_event_filter u_key_filter (
        .clk       (clk),
        .rst       (rst),
        .raw_valid (raw_valid),
        .raw_code  (raw_code),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    game_ctrl u_game_ctrl (
        .clk            (clk),
        .rst            (rst),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .btn            (btn),
        .cell_data      (cell_data),
        .win            (win),
        .place_en       (place_en),
        .cursor_row     (cursor_row),
        .cursor_col     (cursor_col),
        .current_player (current_player),
        .last_row       (last_row),
        .last_col       (last_col),
        .last_player    (last_player),
        .place_result   (place_result),
        .game_over      (game_over),
        .winner         (winner)
    );

    // the stone lands under the cursor in the colour of the player on turn
    board_mem u_board_mem (
        .clk       (clk),
        .rst       (rst),
        .place_en  (place_en),
        .row       (cursor_row),
        .col       (cursor_col),
        .player    (current_player),
        .cell_data (cell_data),
        .board     (board)
    );

    five_row_checker u_checker (
        .board       (board),
        .last_row    (last_row),
        .last_col    (last_col),
        .last_player (last_player),
        .win         (win)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// testbench clock and reset source: 40 ns clock, reset low for 4 cycles at start and on request
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    input  wire  reset_req,   // a rising edge starts another reset
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;   // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset spans 4 rising edges and lets go on a falling edge, clear of the DUT's edge
    always begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(posedge reset_req);              // wait here until the next game is asked for
    end

endmodule

`default_nettype wire

// File: verification/tb_gomoku.sv
// testbench for the gomoku core: table of key and button actions with expected outputs
`timescale 1ns/1ns
`default_nettype none

module tb_gomoku;

    import gomoku_pkg::*;

    typedef enum {ACT_NONE, ACT_KEY, ACT_BTN, ACT_RESET} action_t;

    // one row of the table, the expected values hold once the action has settled
    typedef struct {
        action_t       act;
        key_code_t     code;
        coord_t        row;
        coord_t        col;
        player_t       player;
        place_result_t result;
        logic          over;
        player_t       winner;
    } step_t;

    localparam key_code_t NO_KEY = 4'h0;
    localparam int STEP_CYCLES = 8 + RELEASE_TH + 4;   // longest hold plus the idle gap

    logic          clk;
    logic          rst;
    logic          reset_req;
    logic          raw_valid;
    key_code_t     raw_code;
    logic          btn;
    coord_t        cursor_row;
    coord_t        cursor_col;
    player_t       current_player;
    place_result_t place_result;
    logic          game_over;
    player_t       winner;

    step_t         steps[$];
    logic [7:0]    lfsr;          // hold length source
    int            cycle_cnt;
    int            cycle_limit;

    tb_clock_gen u_clk_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst       (rst)
    );

    gomoku_core u_dut (
        .clk            (clk),
        .rst            (rst),
        .raw_valid      (raw_valid),
        .raw_code       (raw_code),
        .btn            (btn),
        .cursor_row     (cursor_row),
        .cursor_col     (cursor_col),
        .current_player (current_player),
        .place_result   (place_result),
        .game_over      (game_over),
        .winner         (winner)
    );

    // 8-bit Galois LFSR, polynomial x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // three bits, one LFSR step each, give a hold of 1 to 8 cycles
    task automatic pick_hold_len(output int len);
        len = 1;
        for (int b = 0; b < 3; b++) begin
            if (lfsr[0]) len += (1 << b);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_coord(input string field, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                      $time, field, got, exp));
        end
    endtask

    task automatic check_player(input string field, input player_t got, input player_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %s, expected %s",
                                      $time, field, got.name(), exp.name()));
        end
    endtask

    task automatic check_result(input string field, input place_result_t got,
                                input place_result_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %s, expected %s",
                                      $time, field, got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                      $time, field, got, exp));
        end
    endtask

    task automatic add_step(input action_t act, input key_code_t code, input int row,
                            input int col, input player_t player, input place_result_t result,
                            input logic over, input player_t win_player);
        step_t s;
        s.act    = act;
        s.code   = code;
        s.row    = coord_t'(row);
        s.col    = coord_t'(col);
        s.player = player;
        s.result = result;
        s.over   = over;
        s.winner = win_player;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // reset state, then clamping at the top left corner
        add_step(ACT_NONE, NO_KEY, 0, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_UP, 0, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_LEFT, 0, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        // P1 takes (0,0), the button on the same cell is refused and the turn stays
        add_step(ACT_KEY, KEY_PLACE, 0, 0, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_BTN, NO_KEY, 0, 0, PLAYER_2, RESULT_FAIL, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 1, 0, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_BTN, NO_KEY, 1, 0, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        // P1 builds row 0 while P2 answers right below on row 1
        add_step(ACT_KEY, KEY_UP, 0, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 0, 1, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 0, 1, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 1, 1, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 1, 1, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_UP, 0, 1, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 0, 2, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_BTN, NO_KEY, 0, 2, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 1, 2, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 1, 2, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_UP, 0, 2, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 0, 3, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 0, 3, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 1, 3, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 1, 3, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_UP, 0, 3, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 0, 4, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        // fifth stone on row 0 wins, P1 keeps the turn and everything freezes
        add_step(ACT_KEY, KEY_PLACE, 0, 4, PLAYER_1, RESULT_OK, 1'b1, PLAYER_1);
        add_step(ACT_KEY, KEY_LEFT, 0, 4, PLAYER_1, RESULT_OK, 1'b1, PLAYER_1);
        add_step(ACT_KEY, KEY_PLACE, 0, 4, PLAYER_1, RESULT_OK, 1'b1, PLAYER_1);
        add_step(ACT_BTN, NO_KEY, 0, 4, PLAYER_1, RESULT_OK, 1'b1, PLAYER_1);
        // new game, P2 fills the main diagonal from the corner
        add_step(ACT_RESET, NO_KEY, 0, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 0, 1, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_BTN, NO_KEY, 0, 1, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_LEFT, 0, 0, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 0, 0, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 1, 0, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 1, 0, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 1, 1, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 1, 1, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 2, 1, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 2, 1, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 2, 2, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 2, 2, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 3, 2, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 3, 2, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 3, 3, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 3, 3, PLAYER_1, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_DOWN, 4, 3, PLAYER_1, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 4, 3, PLAYER_2, RESULT_OK, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_RIGHT, 4, 4, PLAYER_2, RESULT_NONE, 1'b0, CELL_EMPTY);
        add_step(ACT_KEY, KEY_PLACE, 4, 4, PLAYER_2, RESULT_OK, 1'b1, PLAYER_2);
    endtask

    // every action starts and ends on a falling edge
    task automatic apply_step(input step_t s);
        int hold;
        case (s.act)
            ACT_KEY: begin
                pick_hold_len(hold);
                raw_valid = 1'b1;
                raw_code  = s.code;
                repeat (hold) @(negedge clk);
                raw_valid = 1'b0;
                repeat (RELEASE_TH + 4) @(negedge clk);   // lets the filter re-arm
            end
            ACT_BTN: begin
                btn = 1'b0;
                repeat (2) @(negedge clk);
                btn = 1'b1;
                repeat (4) @(negedge clk);
            end
            ACT_RESET: begin
                reset_req = 1'b1;
                @(negedge clk);
                reset_req = 1'b0;
                wait (rst === 1'b1);                      // released on a falling edge
            end
            default: repeat (RELEASE_TH + 4) @(negedge clk);
        endcase
    endtask

    task automatic check_step(input step_t s);
        check_coord("cursor_row", cursor_row, s.row);
        check_coord("cursor_col", cursor_col, s.col);
        check_player("current_player", current_player, s.player);
        check_result("place_result", place_result, s.result);
        check_flag("game_over", game_over, s.over);
        check_player("winner", winner, s.winner);
    endtask

    // the whole table has a bounded length, so a stuck run ends here
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_with_error("timeout: table did not finish");
        end
    end

    initial begin
        reset_req = 1'b0;
        raw_valid = 1'b0;
        raw_code  = NO_KEY;
        btn       = 1'b1;            // button idles released
        lfsr      = 8'd37;
        cycle_cnt = 0;
        build_table();
        cycle_limit = steps.size() * STEP_CYCLES + 20;
        wait (rst === 1'b1);
        foreach (steps[i]) begin
            apply_step(steps[i]);
            check_step(steps[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/gomoku_pkg.sv
hdl/key_event_filter.sv
hdl/game_ctrl.sv
hdl/board_mem.sv
hdl/five_row_checker.sv
hdl/gomoku_core.sv
verification/tb_clock_gen.sv
verification/tb_gomoku.sv

// File: Makefile
# Verilator build and run for the gomoku core testbench

VERILATOR ?= verilator
TOP       ?= tb_gomoku
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
